/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vapu_tb: list.f src/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module apu_tb -f list.f

run: obj_dir/Vapu_tb
	./obj_dir/Vapu_tb | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/apu_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_assert (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic req,
	input logic ack,
	input logic irq
);

	// Four-phase order on the host port
	ack_rise_with_req: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) $rose(ack) |-> $past(req)
	) else $error("ack rose while req was low");

	ack_fall_after_req: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) $fell(ack) |-> !$past(req)
	) else $error("ack fell while req was still high");

	irq_low_after_reset: assert property (
		@(posedge sys_clk) $rose(sys_rst_n) |-> !irq
	) else $error("irq high right after reset");

endmodule

bind apu_host_port apu_assert host_chk (
	.sys_clk(sys_clk),
	.sys_rst_n(sys_rst_n),
	.req(req),
	.ack(ack),
	.irq(irq)
);

`default_nettype wire

/* bench/apu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_tb;
	import apu_pkg::*;

	localparam int FRAME_STEP = 8;
	localparam int ACK_TIMEOUT = 20;
	localparam reg_addr_t REG_STATUS = 5'h15;
	localparam reg_addr_t REG_FRAME = 5'h17;

	// Length loads by index from the hardware length table
	localparam logic [7:0] LENGTH_LOADS [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
		8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
		8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
		8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
	};

	logic sys_clk;
	logic sys_rst_n;
	logic req;
	logic we;
	reg_addr_t addr;
	reg_data_t wdata;
	reg_data_t rdata;
	logic ack;
	logic irq;
	sample_t out;

	int errors;
	int checks;
	int tests;
	logic [31:0] rng;

	apu_top #(.FRAME_STEP(FRAME_STEP)) dut0 (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.ack(ack),
		.irq(irq),
		.out(out)
	);

	always #10 sys_clk = ~sys_clk;

	function automatic logic [31:0] xorshift_next(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s did not happen in time", $time, what);
		errors++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge sys_clk);
	endtask

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (ack !== level && n < ACK_TIMEOUT) begin
			@(negedge sys_clk);
			n++;
		end
		if (ack !== level)
			report_timeout(what);
	endtask

	task automatic bus_write(input reg_addr_t a, input reg_data_t d);
		@(negedge sys_clk);
		req = 1'b1;
		we = 1'b1;
		addr = a;
		wdata = d;
		wait_ack(1'b1, "ack rise on write");
		req = 1'b0;
		we = 1'b0;
		wait_ack(1'b0, "ack fall on write");
	endtask

	task automatic bus_read(input reg_addr_t a, output reg_data_t d);
		@(negedge sys_clk);
		req = 1'b1;
		we = 1'b0;
		addr = a;
		wait_ack(1'b1, "ack rise on read");
		d = rdata;
		req = 1'b0;
		wait_ack(1'b0, "ack fall on read");
	endtask

	task automatic pulse_setup(input logic ch, input logic [1:0] duty, input logic halt,
		input logic [3:0] vol, input logic [10:0] period, input logic [4:0] idx);
		reg_addr_t base;
		base = {2'b00, ch, 2'b00};
		bus_write(base | 5'd0, {duty, halt, 1'b0, vol});
		bus_write(base | 5'd2, period[7:0]);
		bus_write(base | 5'd3, {idx, period[10:8]});
	endtask

	// One bit per sample value seen on out
	task automatic scan_out(input int cycles, output logic [31:0] seen);
		seen = '0;
		repeat (cycles) begin
			@(negedge sys_clk);
			seen[out] = 1'b1;
		end
	endtask

	task automatic watch_irq(input int cycles, output logic seen);
		seen = 1'b0;
		repeat (cycles) begin
			@(negedge sys_clk);
			seen = seen | irq;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("%s: %s", name, (errors == errors_before) ? "passed" : "failed");
	endtask

	task automatic test_reset_state();
		int e;
		reg_data_t rd;
		e = errors;
		check("out", out, 0);
		check("irq", irq, 0);
		check("ack", ack, 0);
		bus_read(REG_STATUS, rd);
		check("status", rd, 0);
		finish_test("reset_state", e);
	endtask

	task automatic test_tone();
		int e;
		reg_data_t rd;
		logic [3:0] vol;
		logic [4:0] idx;
		logic [31:0] seen;
		e = errors;
		rng = xorshift_next(rng);
		vol = rng[3:0] | 4'd1;
		rng = xorshift_next(rng);
		idx = rng[12:8];
		bus_write(REG_STATUS, 8'h01);
		pulse_setup(1'b0, 2'b10, 1'b1, vol, 11'd20, idx);
		bus_read(REG_STATUS, rd);
		check("status[0]", rd[0], 1);
		// A full duty cycle is 8 x 21 ticks
		scan_out(400, seen);
		check("out values seen", seen, 32'h1 | (32'h1 << vol));
		finish_test("tone", e);
	endtask

	task automatic test_mixing();
		int e;
		int mx;
		logic [3:0] v0;
		logic [3:0] v1;
		logic [31:0] seen;
		e = errors;
		rng = xorshift_next(rng);
		v0 = rng[3:0] | 4'd1;
		v1 = rng[7:4] | 4'd1;
		bus_write(REG_STATUS, 8'h03);
		pulse_setup(1'b0, 2'b11, 1'b1, v0, 11'd20, rng[12:8]);
		pulse_setup(1'b1, 2'b11, 1'b1, v1, 11'd27, rng[20:16]);
		scan_out(400, seen);
		mx = 0;
		for (int i = 0; i < 32; i++)
			if (seen[i])
				mx = i;
		check("out max", mx, v0 + v1);
		finish_test("mixing", e);
	endtask

	task automatic test_length_expiry();
		int e;
		int n;
		int limit;
		reg_data_t rd;
		logic [31:0] seen;
		e = errors;
		bus_write(REG_STATUS, 8'h01);
		pulse_setup(1'b0, 2'b10, 1'b0, 4'hf, 11'd20, 5'd3);
		// A count takes one half frame every two steps and a poll two cycles or more
		limit = (2 * LENGTH_LOADS[3] + 2) * FRAME_STEP;
		bus_read(REG_STATUS, rd);
		check("status[0] loaded", rd[0], 1);
		n = 0;
		while (rd[0] && n < limit) begin
			bus_read(REG_STATUS, rd);
			n++;
		end
		if (rd[0])
			report_timeout("length counter expiry");
		scan_out(100, seen);
		check("out values after expiry", seen, 32'h1);
		pulse_setup(1'b0, 2'b10, 1'b1, 4'hf, 11'd20, 5'd1);
		bus_read(REG_STATUS, rd);
		check("status[0] reloaded", rd[0], 1);
		bus_write(REG_STATUS, 8'h00);
		bus_read(REG_STATUS, rd);
		check("status[0] disabled", rd[0], 0);
		finish_test("length_expiry", e);
	endtask

	task automatic test_frame_irq();
		int e;
		int n;
		reg_data_t rd;
		logic seen;
		e = errors;
		bus_write(REG_FRAME, 8'h00);
		bus_read(REG_STATUS, rd);
		n = 0;
		while (!irq && n < 16 * FRAME_STEP) begin
			@(negedge sys_clk);
			n++;
		end
		if (!irq)
			report_timeout("frame interrupt");
		bus_read(REG_STATUS, rd);
		check("status[6]", rd[6], 1);
		check("irq after status read", irq, 0);
		// Five-step mode raises no interrupt
		bus_write(REG_FRAME, 8'h80);
		bus_read(REG_STATUS, rd);
		watch_irq(3 * 10 * FRAME_STEP, seen);
		check("irq in five-step mode", seen, 0);
		bus_write(REG_FRAME, 8'h40);
		watch_irq(3 * 8 * FRAME_STEP, seen);
		check("irq with inhibit", seen, 0);
		finish_test("frame_irq", e);
	endtask

	initial begin
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		rng = 32'h7f97_a305;
		wait_cycles(3);
		sys_rst_n = 1'b1;
		test_reset_state();
		test_tone();
		test_mixing();
		test_length_expiry();
		test_frame_irq();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
src/apu_pkg.sv
src/chan_ctl_if.sv
src/apu_host_port.sv
src/apu_frame_seq.sv
src/apu_pulse.sv
src/apu_mixer.sv
src/apu_top.sv
bench/apu_assert.sv
bench/apu_tb.sv

/* src/apu_frame_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_frame_seq #(
	parameter int FRAME_STEP = 3728
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic frame_mode,
	input  logic frame_restart,
	output logic apu_tick,
	output logic qframe,
	output logic hframe,
	output logic frame_irq_evt
);
	import apu_pkg::*;

	localparam frame_cnt_t STEP_LOAD = frame_cnt_t'(FRAME_STEP - 1);

	frame_state_t state;
	frame_cnt_t frame_cnt;
	logic step;
	logic restart_pend;
	logic restart_req;

	// Work happens on the edge that raises apu_tick
	assign step = ~apu_tick;
	assign restart_req = restart_pend | frame_restart;

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			apu_tick <= 1'b0;
		else
			apu_tick <= ~apu_tick;
	end

	// Hold a restart until the next tick
	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			restart_pend <= 1'b0;
		else
			restart_pend <= restart_req & ~step;
	end

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S0;
			frame_cnt <= '0;
			qframe <= 1'b0;
			hframe <= 1'b0;
			frame_irq_evt <= 1'b0;
		end else begin
			qframe <= 1'b0;
			hframe <= 1'b0;
			frame_irq_evt <= 1'b0;
			if (step) begin
				if (restart_req) begin
					frame_cnt <= STEP_LOAD;
					state <= S1;
					// Five-step mode clocks the units right away
					qframe <= frame_mode;
					hframe <= frame_mode;
				end else if (frame_cnt != '0) begin
					frame_cnt <= frame_cnt - 1'b1;
				end else begin
					frame_cnt <= STEP_LOAD;
					case (state)
					S0: begin
						qframe <= 1'b1;
						state <= S1;
					end
					S1: begin
						qframe <= 1'b1;
						hframe <= 1'b1;
						state <= S2;
					end
					S2: begin
						qframe <= 1'b1;
						state <= S3;
					end
					S3: begin
						if (frame_mode) begin
							state <= S4;
						end else begin
							qframe <= 1'b1;
							hframe <= 1'b1;
							frame_irq_evt <= 1'b1;
							state <= S0;
						end
					end
					S4: begin
						qframe <= 1'b1;
						hframe <= 1'b1;
						state <= S0;
					end
					default: state <= S0;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/apu_host_port.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_host_port (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               req,
	input  logic               we,
	input  apu_pkg::reg_addr_t addr,
	input  apu_pkg::reg_data_t wdata,
	output apu_pkg::reg_data_t rdata,
	output logic               ack,
	chan_ctl_if.host           ch0,
	chan_ctl_if.host           ch1,
	input  logic               frame_irq_evt,
	output logic               frame_mode,
	output logic               frame_restart,
	output logic               irq
);
	import apu_pkg::*;

	logic access;
	logic ack_drop;
	logic sel_p0;
	logic sel_p1;
	logic sel_status;
	logic sel_frame;
	logic inhibit;
	logic stat_pend;

	// One access per req and ack low again once req is gone
	assign access = req & ~ack;
	assign ack_drop = ack & ~req;

	assign sel_p0 = addr[4:2] == ADDR_PULSE0[4:2];
	assign sel_p1 = addr[4:2] == ADDR_PULSE1[4:2];
	assign sel_status = addr == ADDR_STATUS;
	assign sel_frame = addr == ADDR_FRAME;

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			ack <= 1'b0;
		else if (access)
			ack <= 1'b1;
		else if (ack_drop)
			ack <= 1'b0;
	end

	// Strobes line up with the rising ack
	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ch0.wr <= 1'b0;
			ch1.wr <= 1'b0;
			frame_restart <= 1'b0;
		end else begin
			ch0.wr <= access & we & sel_p0;
			ch1.wr <= access & we & sel_p1;
			frame_restart <= access & we & sel_frame;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (access) begin
			ch0.reg_idx <= addr[1:0];
			ch0.wdata <= wdata;
			ch1.reg_idx <= addr[1:0];
			ch1.wdata <= wdata;
			rdata <= (!we && sel_status) ? {1'b0, irq, 4'b0, ch1.act, ch0.act} : '0;
		end
	end

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ch0.en <= 1'b0;
			ch1.en <= 1'b0;
			frame_mode <= 1'b0;
			inhibit <= 1'b0;
		end else if (access && we) begin
			if (sel_status) begin
				ch0.en <= wdata[0];
				ch1.en <= wdata[1];
			end
			if (sel_frame) begin
				frame_mode <= wdata[7];
				inhibit <= wdata[6];
			end
		end
	end

	// Status read pending until ack falls
	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			stat_pend <= 1'b0;
		else if (access)
			stat_pend <= !we && sel_status;
		else if (ack_drop)
			stat_pend <= 1'b0;
	end

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			irq <= 1'b0;
		else if (frame_irq_evt && !inhibit)
			irq <= 1'b1;
		else if (inhibit || (ack_drop && stat_pend))
			irq <= 1'b0;
	end

endmodule

`default_nettype wire

/* src/apu_mixer.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_mixer (
	input  logic             sys_clk,
	input  logic             sys_rst_n,
	input  apu_pkg::volume_t a,
	input  apu_pkg::volume_t b,
	output apu_pkg::sample_t out
);
	import apu_pkg::*;

	// Linear sum one bit wider than a channel
	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			out <= '0;
		else
			out <= sample_t'(a) + sample_t'(b);
	end

endmodule

`default_nettype wire

/* src/apu_pkg.sv */
`default_nettype none

package apu_pkg;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [7:0]  reg_data_t;
	typedef logic [3:0]  volume_t;
	typedef logic [4:0]  sample_t;
	typedef logic [10:0] timer_t;
	typedef logic [7:0]  length_t;
	typedef logic [11:0] frame_cnt_t;

	typedef enum logic [2:0] {
		S0,
		S1,
		S2,
		S3,
		S4
	} frame_state_t;

	// Pulse channels use four words each
	localparam reg_addr_t ADDR_PULSE0 = 5'h00;
	localparam reg_addr_t ADDR_PULSE1 = 5'h04;
	localparam reg_addr_t ADDR_STATUS = 5'h15;
	localparam reg_addr_t ADDR_FRAME  = 5'h17;

	// Length counter loads indexed by reg 3 bits 7:3
	localparam length_t LENGTH_TABLE [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
		8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
		8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
		8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
	};

endpackage

`default_nettype wire

/* src/apu_pulse.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_pulse (
	input  logic             sys_clk,
	input  logic             sys_rst_n,
	chan_ctl_if.chan         ctl,
	input  logic             apu_tick,
	input  logic             hframe,
	output apu_pkg::volume_t level
);
	import apu_pkg::*;

	logic [1:0] duty;
	logic halt;
	volume_t volume;
	timer_t period;
	timer_t timer;
	length_t length;
	logic [2:0] seq_pos;
	logic [7:0] pattern;
	logic wr_ctl;
	logic wr_tlo;
	logic wr_thi;

	// Register 1 is the sweep unit and has no logic here
	assign wr_ctl = ctl.wr && ctl.reg_idx == 2'd0;
	assign wr_tlo = ctl.wr && ctl.reg_idx == 2'd2;
	assign wr_thi = ctl.wr && ctl.reg_idx == 2'd3;

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			duty <= 2'd0;
			halt <= 1'b0;
			volume <= '0;
			period <= '0;
		end else begin
			if (wr_ctl) begin
				duty <= ctl.wdata[7:6];
				halt <= ctl.wdata[5];
				volume <= ctl.wdata[3:0];
			end
			if (wr_tlo)
				period[7:0] <= ctl.wdata;
			if (wr_thi)
				period[10:8] <= ctl.wdata[2:0];
		end
	end

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			length <= '0;
		else if (!ctl.en)
			length <= '0;
		else if (wr_thi)
			length <= LENGTH_TABLE[ctl.wdata[7:3]];
		else if (hframe && !halt && length != '0)
			length <= length - 1'b1;
	end

	// Timer walks the duty sequence backwards and a reg 3 write restarts it
	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			timer <= '0;
			seq_pos <= 3'd0;
		end else begin
			if (apu_tick) begin
				if (timer == '0) begin
					timer <= period;
					seq_pos <= seq_pos - 1'b1;
				end else begin
					timer <= timer - 1'b1;
				end
			end
			if (wr_thi)
				seq_pos <= 3'd0;
		end
	end

	always_comb begin
		case (duty)
		2'd0: pattern = 8'b0100_0000;
		2'd1: pattern = 8'b0110_0000;
		2'd2: pattern = 8'b0111_1000;
		default: pattern = 8'b1001_1111;
		endcase
	end

	assign ctl.act = length != '0;

	// Short periods are muted as ultrasonic
	assign level = (length != '0 && pattern[seq_pos] && period >= 11'd8) ? volume : '0;

endmodule

`default_nettype wire

/* src/apu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_top #(
	parameter int FRAME_STEP = 3728
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               req,
	input  logic               we,
	input  apu_pkg::reg_addr_t addr,
	input  apu_pkg::reg_data_t wdata,
	output apu_pkg::reg_data_t rdata,
	output logic               ack,
	output logic               irq,
	output apu_pkg::sample_t   out
);
	import apu_pkg::*;

	logic apu_tick;
	logic hframe;
	logic frame_irq_evt;
	logic frame_mode;
	logic frame_restart;
	volume_t p0_level;
	volume_t p1_level;

	chan_ctl_if ch0_if ();
	chan_ctl_if ch1_if ();

	apu_host_port host0 (
		.sys_clk, .sys_rst_n,
		.req, .we, .addr, .wdata, .rdata, .ack,
		.ch0(ch0_if.host),
		.ch1(ch1_if.host),
		.frame_irq_evt, .frame_mode, .frame_restart, .irq
	);

	// Quarter frames only clock envelopes and this design has none
	apu_frame_seq #(.FRAME_STEP(FRAME_STEP)) seq0 (
		.sys_clk, .sys_rst_n,
		.frame_mode, .frame_restart,
		.apu_tick, .qframe(), .hframe, .frame_irq_evt
	);

	apu_pulse p0 (.sys_clk, .sys_rst_n, .ctl(ch0_if.chan), .apu_tick, .hframe, .level(p0_level));
	apu_pulse p1 (.sys_clk, .sys_rst_n, .ctl(ch1_if.chan), .apu_tick, .hframe, .level(p1_level));

	apu_mixer mix0 (.sys_clk, .sys_rst_n, .a(p0_level), .b(p1_level), .out);

endmodule

`default_nettype wire

/* src/chan_ctl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface chan_ctl_if;
	import apu_pkg::*;

	logic      wr;
	logic [1:0] reg_idx;
	reg_data_t wdata;
	logic      en;
	// Length counter still running
	logic      act;

	modport host (
		output wr, reg_idx, wdata, en,
		input  act
	);

	modport chan (
		input  wr, reg_idx, wdata, en,
		output act
	);

endinterface

`default_nettype wire
